// ==== design/sram_defs.svh ====
/* sizes for the two-chip starter board SRAM, 256K words of 32 bits
   changing the data width also needs a matching chip count in the top level */
`ifndef SRAM_DEFS_SVH
`define SRAM_DEFS_SVH

// word address, shared by both chips
`define SRAM_ADDR_W 18

// host word, chip 1 holds the low half and chip 2 the high half
`define SRAM_DATA_W 32

`define SRAM_LANES 4

// queued host requests
`define REQ_FIFO_DEPTH 8

`endif

// ==== design/sram_pkg.sv ====
/* request and pin bundles shared by the SRAM controller blocks */
`default_nettype none
`include "sram_defs.svh"

package sram_pkg;

   // request as the host presents it
   typedef struct packed {
      logic                     write;
      logic [`SRAM_ADDR_W-1:0] addr;
      logic [`SRAM_DATA_W-1:0] wdata;
      logic [`SRAM_LANES-1:0]  byte_en;
   } host_req_t;

   // request as queued for the cycle engine
   typedef struct packed {
      logic                     write;
      logic [`SRAM_ADDR_W-1:0] addr;
      logic [`SRAM_DATA_W-1:0] wdata;
      logic [`SRAM_LANES-1:0]  lane_sel;  // active high, lane 0 is bits 7:0
      logic [1:0]              chip_sel;  // bit 0 chip 1, bit 1 chip 2
   } sram_req_t;

   // pins toward the chips, all strobes active low
   typedef struct packed {
      logic [`SRAM_ADDR_W-1:0] a;
      logic                    oe_n;
      logic                    we_n;
      logic [1:0]              ce_n;      // index 0 is chip 1
      logic [1:0]              ub_n;
      logic [1:0]              lb_n;
   } sram_ctrl_t;

endpackage

`default_nettype wire

// ==== design/host_request_packer.sv ====
/* strobes with no byte enabled are dropped silently
   a request that finds the FIFO full one cycle later is lost and sets overflow */
`default_nettype none
`include "sram_defs.svh"

module host_request_packer
   import sram_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     req_strobe,
   input  logic                     req_write,
   input  logic [`SRAM_ADDR_W-1:0] req_addr,
   input  logic [`SRAM_DATA_W-1:0] req_wdata,
   input  logic [`SRAM_LANES-1:0]  req_byte_en,
   input  logic                     fifo_full,
   output logic                     push,
   output sram_req_t                push_data,
   output logic                     overflow
);

   host_req_t host_req;
   sram_req_t packed_req;
   logic      stage_valid;

   assign host_req = '{write: req_write, addr: req_addr, wdata: req_wdata,
                       byte_en: req_byte_en};

   always_comb
   begin
      packed_req.write       = host_req.write;
      packed_req.addr        = host_req.addr;
      packed_req.wdata       = host_req.wdata;
      packed_req.lane_sel    = host_req.byte_en;
      packed_req.chip_sel[0] = |host_req.byte_en[1:0];  // low half lives in chip 1
      packed_req.chip_sel[1] = |host_req.byte_en[3:2];
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         stage_valid <= 1'b0;
      else
         stage_valid <= req_strobe && (|host_req.byte_en);
   end

   always_ff @(posedge clk)
   begin
      if (req_strobe)
         push_data <= packed_req;
   end

   assign push = stage_valid && !fifo_full;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         overflow <= 1'b0;
      else if (stage_valid && fifo_full)
         overflow <= 1'b1;  // sticky until reset
   end

   // a pushed request always carries at least one lane
   a_push_has_lanes: assert property (@(posedge clk) disable iff (!rst_n)
      push |-> (|push_data.lane_sel));

endmodule

`default_nettype wire

// ==== design/req_fifo.sv ====
/* show-ahead FIFO, head is valid whenever empty is low
   push and pop in the same cycle are both taken */
`default_nettype none
`include "sram_defs.svh"

module req_fifo #(
   parameter type payload_t = logic,
   parameter int  depth     = `REQ_FIFO_DEPTH
)
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     push,
   input  payload_t push_data,
   input  logic     pop,
   output payload_t head,
   output logic     empty,
   output logic     full
);

   localparam int ptr_w = $clog2(depth);

   payload_t         mem [depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [ptr_w:0]   count;

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= push_data;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign head  = mem[rd_ptr];
   assign empty = (count == '0);
   assign full  = (count == (ptr_w + 1)'(depth));

   a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty));
   a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) !(push && full));

endmodule

`default_nettype wire

// ==== design/sram_cycle_engine.sv ====
/* fixed timing, writes take 3 clocks and reads 2 clocks after the pop
   no pad delays are modelled, the chips must settle within one clock */
`default_nettype none
`include "sram_defs.svh"

module sram_cycle_engine
   import sram_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  sram_req_t                head,
   input  logic                     empty,
   output logic                     pop,
   output sram_ctrl_t               ctrl,
   inout  wire  [15:0]              ram1_io,
   inout  wire  [15:0]              ram2_io,
   output logic                     rd_valid,
   output logic [`SRAM_DATA_W-1:0] rd_data
);

   typedef enum logic [2:0] {
      st_idle,
      st_wr_setup,
      st_wr_strobe,
      st_wr_hold,
      st_rd_access,
      st_rd_capture
   } state_t;

   state_t                   state;
   state_t                   state_nxt;
   sram_req_t                req_q;
   logic                     active;
   logic                     wr_drive;
   logic                     rd_enable;
   logic [`SRAM_DATA_W-1:0] lane_mask;

   assign pop = (state == st_idle) && !empty;

   always_comb
   begin
      state_nxt = state;
      case (state)
         st_idle:       if (pop) state_nxt = head.write ? st_wr_setup : st_rd_access;
         st_wr_setup:   state_nxt = st_wr_strobe;
         st_wr_strobe:  state_nxt = st_wr_hold;
         st_wr_hold:    state_nxt = st_idle;
         st_rd_access:  state_nxt = st_rd_capture;
         st_rd_capture: state_nxt = st_idle;
         default:       state_nxt = st_idle;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state <= st_idle;
      else
         state <= state_nxt;
   end

   always_ff @(posedge clk)
   begin
      if (pop)
         req_q <= head;
   end

   assign active    = (state != st_idle);
   assign wr_drive  = (state == st_wr_setup) || (state == st_wr_strobe) || (state == st_wr_hold);
   assign rd_enable = (state == st_rd_access) || (state == st_rd_capture);

   always_comb
   begin
      ctrl.a    = req_q.addr;
      ctrl.oe_n = !rd_enable;
      ctrl.we_n = (state != st_wr_strobe);
      for (int c = 0; c < 2; c++)
      begin
         ctrl.ce_n[c] = !(active && req_q.chip_sel[c]);
         ctrl.lb_n[c] = !(active && req_q.lane_sel[2*c]);    // even lane is the low byte
         ctrl.ub_n[c] = !(active && req_q.lane_sel[2*c+1]);
      end
   end

   assign ram1_io = wr_drive ? req_q.wdata[15:0]  : 16'bz;
   assign ram2_io = wr_drive ? req_q.wdata[31:16] : 16'bz;

   // disabled lanes float on the bus
   always_comb
   begin
      for (int i = 0; i < `SRAM_LANES; i++)
         lane_mask[i*8 +: 8] = {8{req_q.lane_sel[i]}};
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         rd_valid <= 1'b0;
      else
         rd_valid <= (state == st_rd_capture);
   end

   always_ff @(posedge clk)
   begin
      if (state == st_rd_capture)
         rd_data <= {ram2_io, ram1_io} & lane_mask;
   end

   // address and a chip enable are set up a clock before we_n falls
   a_wr_setup: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(ctrl.we_n) |-> $stable(ctrl.a) && !$past(&ctrl.ce_n));

endmodule

`default_nettype wire

// ==== design/sram_chip_256kx16.sv ====
/* behavioral model of one 256Kx16 asynchronous SRAM, simulation only
   no access or hold timing, memory starts cleared */
`default_nettype none
`include "sram_defs.svh"

module sram_chip_256kx16 (
   input  wire [`SRAM_ADDR_W-1:0] a,
   inout  wire [15:0]             io,
   input  wire                    ce_n,
   input  wire                    ub_n,
   input  wire                    lb_n,
   input  wire                    we_n,
   input  wire                    oe_n
);

   localparam int words = 2 ** `SRAM_ADDR_W;

   logic [7:0] ram_h [words];
   logic [7:0] ram_l [words];

   initial
   begin
      for (int i = 0; i < words; i++)
      begin
         ram_h[i] = 8'h00;
         ram_l[i] = 8'h00;
      end
   end

   // each lane drives only while selected
   assign io[15:8] = (ce_n | oe_n | ub_n) ? 8'bz : ram_h[a];
   assign io[7:0]  = (ce_n | oe_n | lb_n) ? 8'bz : ram_l[a];

   // level-sensitive write, follows a and io while we_n is low
   always_latch
   begin
      if (!we_n && !ce_n && !ub_n)
         ram_h[a] <= io[15:8];
   end

   always_latch
   begin
      if (!we_n && !ce_n && !lb_n)
         ram_l[a] <= io[7:0];
   end

endmodule

`default_nettype wire

// ==== design/sram_subsystem.sv ====
/* host strobes are not acknowledged, watch busy before strobing
   rd_valid is a one-clock pulse, reads complete in request order */
`default_nettype none
`include "sram_defs.svh"

module sram_subsystem
   import sram_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     req_strobe,
   input  logic                     req_write,
   input  logic [`SRAM_ADDR_W-1:0] req_addr,
   input  logic [`SRAM_DATA_W-1:0] req_wdata,
   input  logic [`SRAM_LANES-1:0]  req_byte_en,
   output logic                     busy,
   output logic                     overflow,
   output logic                     rd_valid,
   output logic [`SRAM_DATA_W-1:0] rd_data
);

   logic       push;
   logic       pop;
   logic       fifo_empty;
   logic       fifo_full;
   sram_req_t  push_data;
   sram_req_t  fifo_head;
   sram_ctrl_t ctrl;
   wire [15:0] ram1_io;   // bits 15:0 of each word
   wire [15:0] ram2_io;   // bits 31:16

   assign busy = fifo_full;

   host_request_packer u_packer (
      .clk         (clk),
      .rst_n       (rst_n),
      .req_strobe  (req_strobe),
      .req_write   (req_write),
      .req_addr    (req_addr),
      .req_wdata   (req_wdata),
      .req_byte_en (req_byte_en),
      .fifo_full   (fifo_full),
      .push        (push),
      .push_data   (push_data),
      .overflow    (overflow)
   );

   req_fifo #(.payload_t(sram_req_t)) u_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (push),
      .push_data (push_data),
      .pop       (pop),
      .head      (fifo_head),
      .empty     (fifo_empty),
      .full      (fifo_full)
   );

   sram_cycle_engine u_engine (
      .clk      (clk),
      .rst_n    (rst_n),
      .head     (fifo_head),
      .empty    (fifo_empty),
      .pop      (pop),
      .ctrl     (ctrl),
      .ram1_io  (ram1_io),
      .ram2_io  (ram2_io),
      .rd_valid (rd_valid),
      .rd_data  (rd_data)
   );

   sram_chip_256kx16 ram1 (
      .a    (ctrl.a),
      .io   (ram1_io),
      .ce_n (ctrl.ce_n[0]),
      .ub_n (ctrl.ub_n[0]),
      .lb_n (ctrl.lb_n[0]),
      .we_n (ctrl.we_n),
      .oe_n (ctrl.oe_n)
   );

   sram_chip_256kx16 ram2 (
      .a    (ctrl.a),
      .io   (ram2_io),
      .ce_n (ctrl.ce_n[1]),
      .ub_n (ctrl.ub_n[1]),
      .lb_n (ctrl.lb_n[1]),
      .we_n (ctrl.we_n),
      .oe_n (ctrl.oe_n)
   );

endmodule

`default_nettype wire

// ==== test/tb_sram_subsystem.sv ====
/* table-driven testbench, reads are checked against a shadow memory in request order
   chip models start cleared, so words never written read as zero */
`default_nettype none
`include "sram_defs.svh"

module tb_sram_subsystem;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int wait_limit = 100;   // clocks per wait
   localparam int quiet_clks = 20;

   typedef struct packed {
      logic [3:0]              test_id;
      logic                    write;
      logic [`SRAM_ADDR_W-1:0] addr;
      logic [`SRAM_DATA_W-1:0] data;
      logic [`SRAM_LANES-1:0]  be;
   } row_t;

   logic                    clk;
   logic                    rst_n = 1'b0;
   logic                    req_strobe = 1'b0;
   logic                    req_write = 1'b0;
   logic [`SRAM_ADDR_W-1:0] req_addr = '0;
   logic [`SRAM_DATA_W-1:0] req_wdata = '0;
   logic [`SRAM_LANES-1:0]  req_byte_en = '0;
   logic                    busy;
   logic                    overflow;
   logic                    rd_valid;
   logic [`SRAM_DATA_W-1:0] rd_data;

   row_t                    table_q [$];
   logic [`SRAM_DATA_W-1:0] exp_q [$];
   bit   [`SRAM_DATA_W-1:0] shadow [2**`SRAM_ADDR_W];
   logic [31:0]             rng = 32'd39529;
   int                      checks = 0;
   int                      errors = 0;

   sram_subsystem DUT (
      .clk         (clk),
      .rst_n       (rst_n),
      .req_strobe  (req_strobe),
      .req_write   (req_write),
      .req_addr    (req_addr),
      .req_wdata   (req_wdata),
      .req_byte_en (req_byte_en),
      .busy        (busy),
      .overflow    (overflow),
      .rd_valid    (rd_valid),
      .rd_data     (rd_data)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial
   begin
      #1_000_000;
      $display("simulation did not finish in time");
      $display("sim failed");
      $finish;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // enabled lanes take the new byte
   function automatic logic [31:0] lane_merge(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] be);
      logic [31:0] w;
      w = old;
      for (int i = 0; i < 4; i++)
         if (be[i])
            w[i*8 +: 8] = data[i*8 +: 8];
      return w;
   endfunction

   function automatic logic [31:0] mask_lanes(input logic [31:0] word, input logic [3:0] be);
      logic [31:0] w;
      w = '0;
      for (int i = 0; i < 4; i++)
         if (be[i])
            w[i*8 +: 8] = word[i*8 +: 8];
      return w;
   endfunction

   function automatic string test_title(input int id);
      case (id)
         1:       return "reset state";
         2:       return "full-word writes and reads";
         3:       return "partial writes and reads";
         4:       return "back-to-back reads";
         5:       return "zero byte enable";
         default: return "flood and overflow";
      endcase
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("** Error %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic note_failure(input string msg);
      errors++;
      $display("%s", msg);
   endtask

   task automatic report_test(input int id, input int mark);
      $display("test %0d %s: %s", id, test_title(id), (errors == mark) ? "ok" : "FAILED");
   endtask

   task automatic apply_reset();
      @(posedge clk);
      rst_n <= 1'b0;
      req_strobe <= 1'b0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
   endtask

   task automatic add_row(input int id, input logic write, input logic [17:0] addr,
                          input logic [3:0] be);
      row_t r;
      rng = xorshift32(rng);
      r.test_id = 4'(id);
      r.write = write;
      r.addr = addr;
      r.be = be;
      r.data = write ? rng : '0;
      table_q.push_back(r);
   endtask

   // updates the shadow before the strobe, reads complete in order anyway
   task automatic apply_row(input row_t r);
      int waited;
      waited = 0;
      @(negedge clk);
      while (busy && waited < wait_limit)
      begin
         @(negedge clk);
         waited++;
      end
      if (busy)
         note_failure("timeout waiting for busy to clear");
      if (r.write)
         shadow[r.addr] = lane_merge(shadow[r.addr], r.data, r.be);
      else if (r.be != '0)
         exp_q.push_back(mask_lanes(shadow[r.addr], r.be));
      @(posedge clk);
      req_strobe <= 1'b1;
      req_write <= r.write;
      req_addr <= r.addr;
      req_wdata <= r.data;
      req_byte_en <= r.be;
   endtask

   task automatic drain();
      int          waited;
      logic [31:0] exp;
      @(posedge clk);
      req_strobe <= 1'b0;
      while (exp_q.size() > 0)
      begin
         exp = exp_q.pop_front();
         waited = 0;
         do
         begin
            @(negedge clk);
            waited++;
         end
         while (!rd_valid && waited < wait_limit);
         if (rd_valid)
            check("rd_data", rd_data, exp);
         else
            note_failure("timeout waiting for rd_valid");
      end
      repeat (quiet_clks)
      begin
         @(negedge clk);
         if (rd_valid)
            note_failure("rd_valid pulsed with no read pending");
      end
   endtask

   initial
   begin
      int          cur;
      int          mark;
      int          idle;
      int          cycles;
      logic        seen_busy;
      logic [31:0] exp;

      add_row(2, 1, 18'h00000, 4'hf);
      add_row(2, 1, 18'h3ffff, 4'hf);
      add_row(2, 1, 18'h12345, 4'hf);
      add_row(2, 0, 18'h00000, 4'hf);
      add_row(2, 0, 18'h3ffff, 4'hf);
      add_row(2, 0, 18'h12345, 4'hf);
      add_row(3, 1, 18'h00000, 4'b0101);
      add_row(3, 1, 18'h3ffff, 4'b1000);
      add_row(3, 1, 18'h12345, 4'b0110);
      add_row(3, 0, 18'h00000, 4'hf);
      add_row(3, 0, 18'h3ffff, 4'hf);
      add_row(3, 0, 18'h12345, 4'b1001);
      add_row(4, 0, 18'h00000, 4'b0011);
      add_row(4, 0, 18'h12345, 4'hf);
      add_row(4, 0, 18'h3ffff, 4'b1100);
      add_row(4, 0, 18'h00abc, 4'hf);   // never written
      add_row(5, 1, 18'h12345, 4'h0);
      add_row(5, 0, 18'h12345, 4'h0);
      add_row(5, 0, 18'h12345, 4'hf);

      apply_reset();
      mark = errors;
      @(negedge clk);
      check("busy", 32'(busy), 0);
      check("overflow", 32'(overflow), 0);
      check("rd_valid", 32'(rd_valid), 0);
      report_test(1, mark);

      cur = table_q[0].test_id;
      mark = errors;
      foreach (table_q[i])
      begin
         if (table_q[i].test_id != cur)
         begin
            drain();
            report_test(cur, mark);
            cur = table_q[i].test_id;
            mark = errors;
         end
         apply_row(table_q[i]);
      end
      drain();
      report_test(cur, mark);

      // flood with reads of word 0, strobes ignore busy on purpose
      mark = errors;
      seen_busy = 1'b0;
      exp = shadow[0];
      for (int i = 0; i < 3 * `REQ_FIFO_DEPTH; i++)
      begin
         @(posedge clk);
         req_strobe <= 1'b1;
         req_write <= 1'b0;
         req_addr <= '0;
         req_byte_en <= 4'hf;
         @(negedge clk);
         if (busy)
            seen_busy = 1'b1;
      end
      @(posedge clk);
      req_strobe <= 1'b0;
      idle = 0;
      cycles = 0;
      while (idle < quiet_clks && cycles < 20 * wait_limit)
      begin
         @(negedge clk);
         cycles++;
         if (rd_valid)
         begin
            check("rd_data", rd_data, exp);
            idle = 0;
         end
         else
            idle++;
      end
      if (idle < quiet_clks)
         note_failure("timeout waiting for the flooded reads to finish");
      check("busy seen", 32'(seen_busy), 1);
      check("busy", 32'(busy), 0);
      check("overflow", 32'(overflow), 1);
      apply_reset();
      @(negedge clk);
      check("overflow", 32'(overflow), 0);
      report_test(6, mark);

      $display("6 tests, %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+design
design/sram_pkg.sv
design/host_request_packer.sv
design/req_fifo.sv
design/sram_cycle_engine.sv
design/sram_chip_256kx16.sv
design/sram_subsystem.sv
test/tb_sram_subsystem.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tb_sram_subsystem
FILELIST  = sim.f

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^sim passed$$"

clean:
	rm -rf obj_dir
